/* llink_online_sync.sv */
// Online synchronizer for the logic link.
// Delays rx_online by delay_x_value cycles and tx_online by delay_y_value
// cycles. Each delayed flag drops one cycle after its input drops.
// link_up is the registered AND of both delayed flags and gates all
// link traffic in the other blocks.

`timescale 1ns/1ps

module llink_online_sync (
  input  logic        clk_wr        ,
  input  logic        arst_n        ,
  input  logic        tx_online     ,
  input  logic        rx_online     ,
  input  logic [15:0] delay_x_value ,
  input  logic [15:0] delay_y_value ,
  output logic        link_up
);

  logic [15:0] rx_cnt;
  logic [15:0] tx_cnt;
  logic        rx_online_dly;
  logic        tx_online_dly;
  logic        rx_mature;
  logic        tx_mature;

  // Count after this edge reaches the programmed delay
  assign rx_mature = ({1'b0, rx_cnt} + 17'd1) >= {1'b0, delay_x_value};
  assign tx_mature = ({1'b0, tx_cnt} + 17'd1) >= {1'b0, delay_y_value};

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt        <= '0;
      tx_cnt        <= '0;
      rx_online_dly <= 1'b0;
      tx_online_dly <= 1'b0;
      link_up       <= 1'b0;
    end else begin
      // Saturating counters, restarted while offline
      if (!rx_online) begin
        rx_cnt <= '0;
      end else if (rx_cnt != 16'hffff) begin
        rx_cnt <= rx_cnt + 16'd1;
      end
      if (!tx_online) begin
        tx_cnt <= '0;
      end else if (tx_cnt != 16'hffff) begin
        tx_cnt <= tx_cnt + 16'd1;
      end

      rx_online_dly <= rx_online && rx_mature;
      tx_online_dly <= tx_online && tx_mature;
      link_up       <= rx_online_dly && tx_online_dly;
    end
  end

endmodule

/* llink_phy_pack.sv */
// PHY word packer and unpacker for the slave side of the link.
// The rx word is registered every edge, then split into the AW and W
// beats, their push bits and the B credit bit. The tx word carries the
// B beat, its push bit and the AW and W credit bits, and is registered.
// Push and credit bits in both directions are held low while the link
// is down.

`timescale 1ns/1ps

module llink_phy_pack
  import llink_pkg::*;
(
  input  logic             clk_wr    ,
  input  logic             arst_n    ,
  input  logic             link_up   ,
  input  logic [PHY_W-1:0] rx_phy    ,
  input  b_beat_t          b_out     ,
  input  logic             b_push    ,
  input  logic             aw_credit ,
  input  logic             w_credit  ,
  output logic [PHY_W-1:0] tx_phy    ,
  output logic             aw_push   ,
  output aw_beat_t         aw_beat   ,
  output logic             w_push    ,
  output w_beat_t          w_beat    ,
  output logic             b_credit
);

  logic [PHY_W-1:0] rx_q;
  logic [PHY_W-1:0] tx_d;

  ////////////////////////////////////////////////////////////
  // Receive side

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_phy;
    end
  end

  // Ignore far side strobes until the link is up
  assign aw_push  = link_up && rx_q[RX_AW_PUSH];
  assign w_push   = link_up && rx_q[RX_W_PUSH];
  assign b_credit = link_up && rx_q[RX_B_CREDIT];

  assign aw_beat = rx_q[RX_AW_LSB +: $bits(aw_beat_t)];
  assign w_beat  = rx_q[RX_W_LSB +: $bits(w_beat_t)];

  ////////////////////////////////////////////////////////////
  // Transmit side

  always_comb begin
    tx_d = '0;
    if (link_up) begin
      tx_d[TX_B_PUSH]    = b_push;
      tx_d[TX_AW_CREDIT] = aw_credit;
      tx_d[TX_W_CREDIT]  = w_credit;
      // Payload only next to its push, zero otherwise
      if (b_push) begin
        tx_d[TX_B_LSB +: $bits(b_beat_t)] = b_out;
      end
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_d;
    end
  end

endmodule

/* llink_pkg.sv */
// Shared definitions for the credit-based AXI write link, slave side.
// Holds the AXI field widths, the receive FIFO depths, the bit layout
// of the rx and tx PHY words and the beat structs carried on the link.
// Design files pull it in with a wildcard import in the module header.

package llink_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths

  localparam int PHY_W  = 160;
  localparam int ID_W   = 4;
  localparam int ADDR_W = 48;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;

  // B credit counter
  localparam int CRED_W = 8;

  // Receive FIFO depths, also the far side's starting credit
  localparam int AW_DEPTH = 8;
  localparam int W_DEPTH  = 16;

  ////////////////////////////////////////////////////////////
  // rx PHY word layout, bits 145 to 159 unused

  localparam int RX_AW_PUSH  = 0;
  localparam int RX_AW_LSB   = 1;
  localparam int RX_W_PUSH   = 66;
  localparam int RX_W_LSB    = 67;
  localparam int RX_B_CREDIT = 144;

  ////////////////////////////////////////////////////////////
  // tx PHY word layout, bits 9 to 159 unused

  localparam int TX_B_PUSH    = 0;
  localparam int TX_B_LSB     = 1;
  localparam int TX_AW_CREDIT = 7;
  localparam int TX_W_CREDIT  = 8;

  ////////////////////////////////////////////////////////////
  // Beats

  // Write address, 65 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [2:0]        size;
    logic [7:0]        len;
    logic [1:0]        burst;
    logic [ADDR_W-1:0] addr;
  } aw_beat_t;

  // Write data, 77 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  // Write response, 6 bits
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_beat_t;

endpackage

/* llink_rx_fifo.sv */
// Credit-returning receive FIFO for one link channel.
// Beats pushed from the PHY are written on the next edge and shown ahead
// on pop_data while valid is high. Every valid-and-ready edge pops one
// entry and sends one registered credit pulse back to the far side.
// Instantiated once per receive channel with its own width and depth.

`timescale 1ns/1ps

module llink_rx_fifo #(
  parameter int WIDTH = 65,
  parameter int DEPTH = 8
) (
  input  logic             clk_wr    ,
  input  logic             arst_n    ,
  input  logic             push      ,
  input  logic [WIDTH-1:0] push_data ,
  input  logic             ready     ,
  output logic             valid     ,
  output logic [WIDTH-1:0] pop_data  ,
  output logic             credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  assign valid    = (count != '0);
  assign pop_data = mem[rd_ptr];

  // Pushes into a full buffer are dropped
  assign wr_en = push && (count != FULL_CNT);
  assign rd_en = valid && ready;

  ////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy and credit return

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end

      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // One credit per entry taken by the user
      credit <= rd_en;
    end
  end

endmodule

/* llink_slave_sva.sv */
// Link protocol assertions for the receive FIFOs and the B credit stage.
// Bound into every llink_rx_fifo and llink_tx_credit instance below,
// with the inputs a block does not have tied low.

`timescale 1ns/1ps

module llink_slave_sva
  import llink_pkg::*;
(
  input logic              clk_wr      ,
  input logic              arst_n      ,
  input logic              push        ,
  input logic              full        ,
  input logic              link_up     ,
  input logic [CRED_W-1:0] init_credit ,
  input logic              rx_credit   ,
  input logic              send
);

  // Failed assertions so far
  int   fail_cnt = 0;

  // B responses the far side can still take since the link came up
  int   budget;
  logic link_up_q;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_up_q <= 1'b0;
      budget    <= 0;
    end else begin
      link_up_q <= link_up;
      if (link_up && !link_up_q) begin
        budget <= int'(init_credit);
      end else begin
        budget <= budget + int'(rx_credit) - int'(send);
      end
    end
  end

  // Far side stays within its credit
  no_push_when_full: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !(push && full))
    else begin
      $error("push arrived at a full receive FIFO");
      fail_cnt++;
    end

  // Every b_push is covered by initial or returned B credit
  no_send_without_credit: assert property (@(posedge clk_wr) disable iff (!arst_n)
    send |-> budget > 0)
    else begin
      $error("B push sent while the credit counter was zero");
      fail_cnt++;
    end

  strobes_known: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !$isunknown(push) && !$isunknown(send))
    else begin
      $error("push or send strobe is unknown");
      fail_cnt++;
    end

endmodule

bind llink_rx_fifo llink_slave_sva llink_slave_sva_i (
  .clk_wr      (clk_wr),
  .arst_n      (arst_n),
  .push        (push),
  .full        (count == FULL_CNT),
  .link_up     (1'b0),
  .init_credit ('0),
  .rx_credit   (1'b0),
  .send        (1'b0)
);

bind llink_tx_credit llink_slave_sva llink_slave_sva_i (
  .clk_wr      (clk_wr),
  .arst_n      (arst_n),
  .push        (1'b0),
  .full        (1'b0),
  .link_up     (link_up),
  .init_credit (init_credit),
  .rx_credit   (rx_credit),
  .send        (b_push)
);

/* llink_slave_top.f */
llink_pkg.sv
llink_online_sync.sv
llink_rx_fifo.sv
llink_tx_credit.sv
llink_phy_pack.sv
llink_slave_top.sv
llink_slave_sva.sv
tb_llink_slave_top.sv

/* llink_slave_top.sv */
// Top level of the credit-based AXI write link, slave side.
// Received AW and W beats go through their own credit-returning FIFOs
// to the AXI user ports. B responses from the user leave on tx_phy under
// the control of a credit counter. The online synchronizer holds the
// whole link off until both online inputs have matured.

`timescale 1ns/1ps

module llink_slave_top
  import llink_pkg::*;
(
  input  logic              clk_wr        ,
  input  logic              arst_n        ,

  // Configuration
  input  logic              tx_online     ,
  input  logic              rx_online     ,
  input  logic [15:0]       delay_x_value ,
  input  logic [15:0]       delay_y_value ,
  input  logic [CRED_W-1:0] init_b_credit ,

  // PHY words
  input  logic [PHY_W-1:0]  rx_phy        ,
  output logic [PHY_W-1:0]  tx_phy        ,

  // AW channel
  output logic [ID_W-1:0]   user_awid     ,
  output logic [2:0]        user_awsize   ,
  output logic [7:0]        user_awlen    ,
  output logic [1:0]        user_awburst  ,
  output logic [ADDR_W-1:0] user_awaddr   ,
  output logic              user_awvalid  ,
  input  logic              user_awready  ,

  // W channel
  output logic [ID_W-1:0]   user_wid      ,
  output logic [DATA_W-1:0] user_wdata    ,
  output logic [STRB_W-1:0] user_wstrb    ,
  output logic              user_wlast    ,
  output logic              user_wvalid   ,
  input  logic              user_wready   ,

  // B channel
  input  logic [ID_W-1:0]   user_bid      ,
  input  logic [1:0]        user_bresp    ,
  input  logic              user_bvalid   ,
  output logic              user_bready
);

  logic     link_up;
  logic     aw_push;
  aw_beat_t aw_rx_beat;
  aw_beat_t aw_pop_beat;
  logic     aw_credit;
  logic     w_push;
  w_beat_t  w_rx_beat;
  w_beat_t  w_pop_beat;
  logic     w_credit;
  b_beat_t  b_in_beat;
  b_beat_t  b_tx_beat;
  logic     b_push;
  logic     b_credit;

  ////////////////////////////////////////////////////////////
  // User side packing

  assign user_awid    = aw_pop_beat.id;
  assign user_awsize  = aw_pop_beat.size;
  assign user_awlen   = aw_pop_beat.len;
  assign user_awburst = aw_pop_beat.burst;
  assign user_awaddr  = aw_pop_beat.addr;

  assign user_wid   = w_pop_beat.id;
  assign user_wdata = w_pop_beat.data;
  assign user_wstrb = w_pop_beat.strb;
  assign user_wlast = w_pop_beat.last;

  assign b_in_beat.id   = user_bid;
  assign b_in_beat.resp = user_bresp;

  ////////////////////////////////////////////////////////////
  // Link blocks

  llink_online_sync llink_online_sync_i (
    .clk_wr        (clk_wr),
    .arst_n        (arst_n),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .link_up       (link_up)
  );

  llink_phy_pack llink_phy_pack_i (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .link_up   (link_up),
    .rx_phy    (rx_phy),
    .b_out     (b_tx_beat),
    .b_push    (b_push),
    .aw_credit (aw_credit),
    .w_credit  (w_credit),
    .tx_phy    (tx_phy),
    .aw_push   (aw_push),
    .aw_beat   (aw_rx_beat),
    .w_push    (w_push),
    .w_beat    (w_rx_beat),
    .b_credit  (b_credit)
  );

  llink_rx_fifo #(.WIDTH($bits(aw_beat_t)), .DEPTH(AW_DEPTH)) llink_rx_fifo_iaw (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .push      (aw_push),
    .push_data (aw_rx_beat),
    .ready     (user_awready),
    .valid     (user_awvalid),
    .pop_data  (aw_pop_beat),
    .credit    (aw_credit)
  );

  llink_rx_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(W_DEPTH)) llink_rx_fifo_iw (
    .clk_wr    (clk_wr),
    .arst_n    (arst_n),
    .push      (w_push),
    .push_data (w_rx_beat),
    .ready     (user_wready),
    .valid     (user_wvalid),
    .pop_data  (w_pop_beat),
    .credit    (w_credit)
  );

  llink_tx_credit llink_tx_credit_ib (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .link_up     (link_up),
    .init_credit (init_b_credit),
    .b_in        (b_in_beat),
    .b_valid     (user_bvalid),
    .rx_credit   (b_credit),
    .b_ready     (user_bready),
    .b_out       (b_tx_beat),
    .b_push      (b_push)
  );

endmodule

/* llink_tx_credit.sv */
// Credit-limited transmit stage for the B channel.
// The counter loads init_credit when link_up rises, drops by one per
// accepted response and rises by one per credit pulse from the far side.
// Each accepted response is registered with a one-cycle push towards
// the PHY packer.

`timescale 1ns/1ps

module llink_tx_credit
  import llink_pkg::*;
(
  input  logic              clk_wr      ,
  input  logic              arst_n      ,
  input  logic              link_up     ,
  input  logic [CRED_W-1:0] init_credit ,
  input  b_beat_t           b_in        ,
  input  logic              b_valid     ,
  input  logic              rx_credit   ,
  output logic              b_ready     ,
  output b_beat_t           b_out       ,
  output logic              b_push
);

  logic [CRED_W-1:0] credit_cnt;
  logic              link_up_q;
  logic              accept;

  assign b_ready = link_up && (credit_cnt != '0);
  assign accept  = b_valid && b_ready;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_up_q  <= 1'b0;
      credit_cnt <= '0;
      b_push     <= 1'b0;
    end else begin
      link_up_q <= link_up;
      b_push    <= accept;

      if (!link_up) begin
        credit_cnt <= '0;
      end else if (!link_up_q) begin
        // Link just came up
        credit_cnt <= init_credit;
      end else begin
        // Send and refill in one cycle cancel out
        case ({accept, rx_credit})
          2'b10:   credit_cnt <= credit_cnt - 1'b1;
          2'b01:   credit_cnt <= credit_cnt + 1'b1;
          default: credit_cnt <= credit_cnt;
        endcase
      end
    end
  end

  // Outgoing response payload
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      b_out <= b_in;
    end
  end

endmodule

/* tb_llink_slave_top.sv */
// Directed testbench for the slave side of the credit-based AXI write link.
// Acts as the far-side master on rx_phy and tx_phy, keeping its own AW and
// W credit counts, and as the AXI user on the AW, W and B ports.
// Runs reset, online gating, AW delivery, W back-pressure and B credit tests.

`timescale 1ns/1ps

module tb_llink_slave_top
  import llink_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int AW_BEATS   = 12;
  localparam int DELAY_X    = 5;
  localparam int DELAY_Y    = 3;
  // Reset, gating, AW, W and B test lengths in cycles, then a margin
  localparam int RUN_CYCLES = 12 + 20 + 100 + 45 + 30 + 100;

  logic              clk_wr;
  logic              arst_n;
  logic              tx_online;
  logic              rx_online;
  logic [15:0]       delay_x_value;
  logic [15:0]       delay_y_value;
  logic [CRED_W-1:0] init_b_credit;
  logic [PHY_W-1:0]  rx_phy;
  logic [PHY_W-1:0]  tx_phy;
  logic [ID_W-1:0]   user_awid;
  logic [2:0]        user_awsize;
  logic [7:0]        user_awlen;
  logic [1:0]        user_awburst;
  logic [ADDR_W-1:0] user_awaddr;
  logic              user_awvalid;
  logic              user_awready;
  logic [ID_W-1:0]   user_wid;
  logic [DATA_W-1:0] user_wdata;
  logic [STRB_W-1:0] user_wstrb;
  logic              user_wlast;
  logic              user_wvalid;
  logic              user_wready;
  logic [ID_W-1:0]   user_bid;
  logic [1:0]        user_bresp;
  logic              user_bvalid;
  logic              user_bready;

  // Far side state
  int          aw_cred;
  int          w_cred;
  int          aw_cred_seen;
  int          w_cred_seen;
  b_beat_t     b_seen[$];
  b_beat_t     b_exp[$];
  b_beat_t     b_cur;
  logic [15:0] lfsr;

  llink_slave_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  // Far side view of tx_phy
  always @(negedge clk_wr) begin
    if (arst_n) begin
      if (tx_phy[TX_AW_CREDIT]) begin
        aw_cred++;
        aw_cred_seen++;
      end
      if (tx_phy[TX_W_CREDIT]) begin
        w_cred++;
        w_cred_seen++;
      end
      if (tx_phy[TX_B_PUSH]) begin
        b_seen.push_back(b_beat_t'(tx_phy[TX_B_LSB +: $bits(b_beat_t)]));
      end
    end
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Simulation timed out before all tests finished");
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

  // Stop soon after any bound assertion fires
  always @(negedge clk_wr) begin
    if (assertion_failures() != 0) begin
      $display("A bound assertion failed during the run");
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic compare(input string what, input logic [127:0] got,
                         input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Failures counted in the three bound checker instances
  function automatic int assertion_failures();
    assertion_failures = dut0.llink_rx_fifo_iaw.llink_slave_sva_i.fail_cnt
                       + dut0.llink_rx_fifo_iw.llink_slave_sva_i.fail_cnt
                       + dut0.llink_tx_credit_ib.llink_slave_sva_i.fail_cnt;
  endfunction

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    next_lfsr = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  function automatic logic [PHY_W-1:0] aw_word(input aw_beat_t b);
    aw_word = '0;
    aw_word[RX_AW_PUSH] = 1'b1;
    aw_word[RX_AW_LSB +: $bits(aw_beat_t)] = b;
  endfunction

  function automatic logic [PHY_W-1:0] w_word(input w_beat_t b);
    w_word = '0;
    w_word[RX_W_PUSH] = 1'b1;
    w_word[RX_W_LSB +: $bits(w_beat_t)] = b;
  endfunction

  task automatic expect_idle();
    compare("user_awvalid", user_awvalid, 0);
    compare("user_wvalid", user_wvalid, 0);
    compare("user_bready", user_bready, 0);
    compare("tx_phy B push", tx_phy[TX_B_PUSH], 0);
    compare("tx_phy AW credit", tx_phy[TX_AW_CREDIT], 0);
    compare("tx_phy W credit", tx_phy[TX_W_CREDIT], 0);
  endtask

  // Holds bvalid for some cycles and counts accepted responses
  task automatic offer_b(input int cycles, output int accepted);
    logic [127:0] r;
    accepted = 0;
    repeat (cycles) begin
      @(negedge clk_wr);
      if (user_bvalid && user_bready) begin
        b_exp.push_back(b_cur);
        accepted++;
        take_bits($bits(b_beat_t), r);
        b_cur = r[$bits(b_beat_t)-1:0];
      end
      @(posedge clk_wr);
      user_bid   <= b_cur.id;
      user_bresp <= b_cur.resp;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic reset_state();
    repeat (8) begin
      @(negedge clk_wr);
      expect_idle();
    end
    @(posedge clk_wr);
    arst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk_wr);
      expect_idle();
    end
  endtask

  task automatic online_gating();
    int n;
    @(posedge clk_wr);
    rx_online <= 1'b1;
    // tx side still offline, every push is dropped
    for (n = 0; n < DELAY_X + 4; n++) begin
      @(posedge clk_wr);
      rx_phy <= n[0] ? '0 : (aw_word(aw_beat_t'(65'h1234)) | w_word(w_beat_t'(77'h5678)));
      @(negedge clk_wr);
      expect_idle();
    end
    @(posedge clk_wr);
    rx_phy    <= '0;
    tx_online <= 1'b1;
    n = 0;
    while (!user_bready && n < DELAY_Y + 3) begin
      @(negedge clk_wr);
      n++;
    end
    compare("user_bready after both online", user_bready, 1);
    compare("user_bready not before tx delay", n > DELAY_Y, 1);
    compare("user_awvalid after gating", user_awvalid, 0);
    compare("user_wvalid after gating", user_wvalid, 0);
  endtask

  task automatic aw_delivery();
    aw_beat_t     beat;
    aw_beat_t     exp_q[$];
    logic [127:0] r;
    int           sent;
    int           taken;
    int           start;
    sent  = 0;
    taken = 0;
    start = aw_cred_seen;
    while (taken < AW_BEATS) begin
      @(posedge clk_wr);
      if (sent < AW_BEATS && aw_cred > 0) begin
        take_bits($bits(aw_beat_t), r);
        beat = r[$bits(aw_beat_t)-1:0];
        rx_phy <= aw_word(beat);
        exp_q.push_back(beat);
        aw_cred--;
        sent++;
      end else begin
        rx_phy <= '0;
      end
      take_bits(1, r);
      user_awready <= r[0];
      @(negedge clk_wr);
      if (user_awvalid && user_awready) begin
        compare("AW beat outstanding", exp_q.size() > 0, 1);
        beat = exp_q.pop_front();
        compare("user_awid", user_awid, beat.id);
        compare("user_awsize", user_awsize, beat.size);
        compare("user_awlen", user_awlen, beat.len);
        compare("user_awburst", user_awburst, beat.burst);
        compare("user_awaddr", user_awaddr, beat.addr);
        taken++;
      end
    end
    @(posedge clk_wr);
    user_awready <= 1'b0;
    rx_phy       <= '0;
    // Credit reaches tx_phy two cycles after the last pop
    repeat (4) @(posedge clk_wr);
    compare("AW credit pulses", aw_cred_seen - start, AW_BEATS);
    compare("far side AW credit", aw_cred, AW_DEPTH);
    @(negedge clk_wr);
    compare("user_awvalid after drain", user_awvalid, 0);
  endtask

  task automatic w_backpressure();
    w_beat_t      beat;
    w_beat_t      exp_q[$];
    logic [127:0] r;
    int           start;
    int           taken;
    start = w_cred_seen;
    taken = 0;
    repeat (W_DEPTH) begin
      @(posedge clk_wr);
      take_bits($bits(w_beat_t), r);
      beat = r[$bits(w_beat_t)-1:0];
      rx_phy <= w_word(beat);
      exp_q.push_back(beat);
      w_cred--;
    end
    @(posedge clk_wr);
    rx_phy <= '0;
    repeat (4) @(posedge clk_wr);
    compare("W credits while stalled", w_cred_seen - start, 0);
    @(negedge clk_wr);
    compare("user_wvalid while stalled", user_wvalid, 1);
    @(posedge clk_wr);
    user_wready <= 1'b1;
    while (taken < W_DEPTH) begin
      @(negedge clk_wr);
      if (user_wvalid && user_wready) begin
        compare("user_wid", user_wid, exp_q[taken].id);
        compare("user_wdata", user_wdata, exp_q[taken].data);
        compare("user_wstrb", user_wstrb, exp_q[taken].strb);
        compare("user_wlast", user_wlast, exp_q[taken].last);
        taken++;
      end
    end
    @(posedge clk_wr);
    user_wready <= 1'b0;
    repeat (4) @(posedge clk_wr);
    compare("W credit pulses", w_cred_seen - start, W_DEPTH);
    compare("far side W credit", w_cred, W_DEPTH);
    @(negedge clk_wr);
    compare("user_wvalid after drain", user_wvalid, 0);
  endtask

  task automatic b_credit_limit();
    logic [127:0] r;
    int           acc;
    take_bits($bits(b_beat_t), r);
    b_cur = r[$bits(b_beat_t)-1:0];
    @(posedge clk_wr);
    user_bid    <= b_cur.id;
    user_bresp  <= b_cur.resp;
    user_bvalid <= 1'b1;
    offer_b(10, acc);
    compare("B responses on initial credit", acc, 2);
    @(negedge clk_wr);
    compare("user_bready with no credit", user_bready, 0);
    // One credit returned by the far side
    @(posedge clk_wr);
    rx_phy <= PHY_W'(1) << RX_B_CREDIT;
    @(posedge clk_wr);
    rx_phy <= '0;
    offer_b(6, acc);
    compare("B responses on returned credit", acc, 1);
    @(posedge clk_wr);
    user_bvalid <= 1'b0;
    repeat (3) @(posedge clk_wr);
    compare("B pushes on tx_phy", b_seen.size(), 3);
    for (int i = 0; i < 3; i++) begin
      compare("B id on tx_phy", b_seen[i].id, b_exp[i].id);
      compare("B resp on tx_phy", b_seen[i].resp, b_exp[i].resp);
    end
  endtask

  initial begin
    clk_wr        = 1'b0;
    arst_n        = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = 16'(DELAY_X);
    delay_y_value = 16'(DELAY_Y);
    init_b_credit = CRED_W'(2);
    rx_phy        = '0;
    user_awready  = 1'b0;
    user_wready   = 1'b0;
    user_bid      = '0;
    user_bresp    = '0;
    user_bvalid   = 1'b0;
    lfsr          = 16'd51599;
    aw_cred       = AW_DEPTH;
    w_cred        = W_DEPTH;
    aw_cred_seen  = 0;
    w_cred_seen   = 0;

    reset_state();
    online_gating();
    aw_delivery();
    w_backpressure();
    b_credit_limit();

    if (assertion_failures() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion failure");
    end
  end

endmodule
